/* Makefile */
# Verilator simulation of the timer testbench, every variable can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= timerTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# build, run, then decide by the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/csrBusPkg.sv */
// CSR bus widths and operation codes; word addressed, one request in flight at a time
package csrBusPkg;

  // word address, enough for 16 registers
  localparam int AddrW = 4;

  // data width of every register
  localparam int DataW = 32;

  // decoded bus operation, read and write are never raised together
  typedef enum logic [1:0] {
    csrOpNone  = 2'd0,
    csrOpRead  = 2'd1,
    csrOpWrite = 2'd2
  } csrOpE;

endpackage

/* hdl/timerCore.sv */
// interval timer core; a period of 0 counts as 1, irq lags expired by one cycle
`timescale 1ns/1ps

module timerCore (
  input  logic       clock,
  input  logic       resetSync,
  output logic       irq,
  timerCtrlIf.core   ctrl
);
  import timerPkg::*;

  timerStateE         state;
  logic [PeriodW-1:0] periodEff;
  logic               hitPeriod;
  logic               setExpired;

  assign periodEff  = (ctrl.period == '0) ? PeriodW'(1) : ctrl.period;
  assign hitPeriod  = (ctrl.count == periodEff);
  assign setExpired = (state == timerRun) && ctrl.enable && hitPeriod;

  always_ff @(posedge clock) begin
    if (resetSync) begin
      state      <= timerIdle;
      ctrl.count <= '0;
    end else begin
      case (state)
        timerIdle: begin
          ctrl.count <= '0;
          if (ctrl.enable) state <= timerRun;  // count starts from 0
        end
        timerRun: begin
          if (!ctrl.enable) begin
            state      <= timerIdle;
            ctrl.count <= '0;
          end else if (hitPeriod) begin
            ctrl.count <= '0;
            if (ctrl.mode == modeOneShot) state <= timerDone;
          end else begin
            ctrl.count <= ctrl.count + 1'b1;
          end
        end
        timerDone: begin
          // count holds until enable drops
          if (!ctrl.enable) begin
            state      <= timerIdle;
            ctrl.count <= '0;
          end
        end
        default: begin
          state      <= timerIdle;
          ctrl.count <= '0;
        end
      endcase
    end
  end

  // sticky flag, a new expiry wins over a clear on the same edge
  always_ff @(posedge clock) begin
    if (resetSync) begin
      ctrl.expired <= 1'b0;
      irq          <= 1'b0;
    end else begin
      ctrl.expired <= setExpired || (ctrl.expired && !ctrl.clearExpired);
      irq          <= ctrl.expired && ctrl.irqEnable;
    end
  end

  assign ctrl.running = (state == timerRun);

endmodule

/* hdl/timerCtrlIf.sv */
// config, status and clear strobe between register block and timer core; single clock domain
`timescale 1ns/1ps

interface timerCtrlIf (
  input logic clock
);
  import timerPkg::*;

  // config, driven by the register block
  logic                 enable;
  timerModeE            mode;
  logic                 irqEnable;
  logic [PeriodW-1:0]   period;
  logic                 clearExpired;  // one cycle, from the STATUS read strobe

  // status, driven by the core
  logic [PeriodW-1:0]   count;
  logic                 expired;
  logic                 running;

  modport regs (
    input  clock, count, expired, running,
    output enable, mode, irqEnable, period, clearExpired
  );

  modport core (
    input  clock, enable, mode, irqEnable, period, clearExpired,
    output count, expired, running
  );

endinterface

/* hdl/timerPkg.sv */
// fixed register map of the interval timer; masks assume NumCsr words of csrBusPkg::DataW bits
package timerPkg;

  localparam int NumCsr = 5;

  // register indices
  localparam int RegCtrl   = 0;
  localparam int RegPeriod = 1;
  localparam int RegCount  = 2;
  localparam int RegStatus = 3;
  localparam int RegId     = 4;

  localparam int PeriodW = 16;
  localparam logic [csrBusPkg::DataW-1:0] IdValue = 32'h71AE0001;

  // ctrl and status bit positions
  localparam int CtrlEnableBit    = 0;
  localparam int CtrlOneShotBit   = 1;
  localparam int CtrlIrqEnableBit = 2;
  localparam int StatusExpiredBit = 0;
  localparam int StatusRunningBit = 1;

  // per register bit kinds, word order is CTRL, PERIOD, COUNT, STATUS, ID
  localparam bit [0:NumCsr-1][csrBusPkg::DataW-1:0] CsrFixedBits =
    '{32'h0, 32'h0, 32'h0, 32'h0, 32'hFFFF_FFFF};
  localparam bit [0:NumCsr-1][csrBusPkg::DataW-1:0] CsrInitBits =
    '{32'h0, 32'h0, 32'h0, 32'h0, IdValue};
  localparam bit [0:NumCsr-1][csrBusPkg::DataW-1:0] CsrRwBits =
    '{32'h7, 32'h0000_FFFF, 32'h0, 32'h0, 32'h0};
  localparam bit [0:NumCsr-1][csrBusPkg::DataW-1:0] CsrRoBits =
    '{32'h0, 32'h0, 32'h0000_FFFF, 32'h3, 32'h0};
  localparam bit [0:NumCsr-1][csrBusPkg::DataW-1:0] CsrWoBits = '0;  // none in this map

  typedef enum logic [1:0] {timerIdle, timerRun, timerDone} timerStateE;
  typedef enum logic {modeFree, modeOneShot} timerModeE;

endpackage

/* hdl/timerRegs.sv */
// CSR block for the timer; requests held until ready, ready is a single-cycle pulse, no select
`timescale 1ns/1ps

module timerRegs (
  input  logic                        clock,
  input  logic                        resetSync,
  input  logic                        csrRead,
  input  logic                        csrWrite,
  input  logic [csrBusPkg::AddrW-1:0] csrAddress,
  input  logic [csrBusPkg::DataW-1:0] csrWdata,
  output logic [csrBusPkg::DataW-1:0] csrRdata,
  output logic                        csrReady,
  output logic                        csrError,
  timerCtrlIf.regs                    ctrl
);
  import csrBusPkg::*;
  import timerPkg::*;

  csrOpE                          csrOp;
  logic                           reqNew;     // request not yet answered
  logic                           addrValid;
  logic [0:NumCsr-1][DataW-1:0]   csrConfig;
  logic [0:NumCsr-1][DataW-1:0]   csrStatus;
  logic [0:NumCsr-1][DataW-1:0]   csrReadValue;
  logic [DataW-1:0]               readMux;
  logic [0:NumCsr-1]              rdStrobe;
  logic [0:NumCsr-1]              wrStrobe;

  always_comb begin
    if (csrWrite) csrOp = csrOpWrite;
    else if (csrRead) csrOp = csrOpRead;
    else csrOp = csrOpNone;
  end

  assign reqNew    = (csrOp != csrOpNone) && !csrReady;
  assign addrValid = (csrAddress < NumCsr);

  // status words as seen from the core
  always_comb begin
    csrStatus = '0;
    csrStatus[RegCount][PeriodW-1:0] = ctrl.count;
    csrStatus[RegStatus][StatusExpiredBit] = ctrl.expired;
    csrStatus[RegStatus][StatusRunningBit] = ctrl.running;
  end

  // read value per register, bits outside every mask read as zero
  always_comb begin
    for (int i = 0; i < NumCsr; i++) begin
      csrReadValue[i] = (csrConfig[i] & CsrRwBits[i] & ~CsrWoBits[i] & ~CsrRoBits[i]
                         & ~CsrFixedBits[i])
                      | (csrStatus[i] & CsrRoBits[i] & ~CsrFixedBits[i])
                      | (CsrInitBits[i] & CsrFixedBits[i]);
    end
  end

  assign readMux = addrValid ? csrReadValue[csrAddress] : '0;

  // ready is the registered answer, one strobe or the error flag
  assign csrReady = (|rdStrobe) || (|wrStrobe) || csrError;

  // read data, held until the next read, cleared by a write
  always_ff @(posedge clock) begin
    if (reqNew && csrOp == csrOpRead) csrRdata <= readMux;
    else if (reqNew && csrOp == csrOpWrite) csrRdata <= '0;
  end

  always_ff @(posedge clock) begin
    if (resetSync) begin
      csrConfig <= CsrInitBits;
      rdStrobe  <= '0;
      wrStrobe  <= '0;
      csrError  <= 1'b0;
    end else begin
      rdStrobe <= '0;
      wrStrobe <= '0;
      csrError <= reqNew && !addrValid;  // drops again after the ready cycle
      for (int i = 0; i < NumCsr; i++) begin
        if (reqNew && i == csrAddress) begin
          if (csrOp == csrOpWrite) begin
            csrConfig[i] <= (CsrFixedBits[i] & CsrInitBits[i])
                          | (csrWdata & (CsrRwBits[i] | CsrWoBits[i]) & ~CsrFixedBits[i]);
            wrStrobe[i] <= 1'b1;
          end
          if (csrOp == csrOpRead) rdStrobe[i] <= 1'b1;
        end
      end
    end
  end

  // config out to the core
  assign ctrl.enable       = csrConfig[RegCtrl][CtrlEnableBit];
  assign ctrl.mode         = timerModeE'(csrConfig[RegCtrl][CtrlOneShotBit]);
  assign ctrl.irqEnable    = csrConfig[RegCtrl][CtrlIrqEnableBit];
  assign ctrl.period       = csrConfig[RegPeriod][PeriodW-1:0];
  assign ctrl.clearExpired = rdStrobe[RegStatus];  // clear on STATUS read

endmodule

/* hdl/timerTop.sv */
// timer top level; bus handshake is request held until a one-cycle ready, no back-pressure
`timescale 1ns/1ps

module timerTop (
  input  logic                        clock,
  input  logic                        resetSync,
  input  logic                        csrRead,
  input  logic                        csrWrite,
  input  logic [csrBusPkg::AddrW-1:0] csrAddress,
  input  logic [csrBusPkg::DataW-1:0] csrWdata,
  output logic [csrBusPkg::DataW-1:0] csrRdata,
  output logic                        csrReady,
  output logic                        csrError,
  output logic                        irq
);

  // config and status between the blocks
  timerCtrlIf ctrlIf (
    .clock (clock)
  );

  timerRegs i_timerRegs (
    .clock      (clock),
    .resetSync  (resetSync),
    .csrRead    (csrRead),
    .csrWrite   (csrWrite),
    .csrAddress (csrAddress),
    .csrWdata   (csrWdata),
    .csrRdata   (csrRdata),
    .csrReady   (csrReady),
    .csrError   (csrError),
    .ctrl       (ctrlIf.regs)
  );

  timerCore i_timerCore (
    .clock     (clock),
    .resetSync (resetSync),
    .irq       (irq),
    .ctrl      (ctrlIf.core)
  );

endmodule

/* src.f */
hdl/csrBusPkg.sv
hdl/timerPkg.sv
hdl/timerCtrlIf.sv
hdl/timerRegs.sv
hdl/timerCore.sv
hdl/timerTop.sv
testbench/timerTop_sva.sv
testbench/timerChecker.sv
testbench/timerTb.sv

/* testbench/timerChecker.sv */
// compares read data and error with expected values in the ready cycle, sampled on the falling edge
`timescale 1ns/1ps

module timerChecker (
  input  logic                        clock,
  input  logic                        resetSync,
  input  logic [csrBusPkg::AddrW-1:0] csrAddress,
  input  logic [csrBusPkg::DataW-1:0] csrRdata,
  input  logic                        csrReady,
  input  logic                        csrError,
  input  logic                        expValid,
  input  logic [csrBusPkg::DataW-1:0] expData,
  input  logic                        expError,
  output int                          errorCount
);

  // falling edge keeps clear of the registered outputs changing
  always @(negedge clock) begin
    if (resetSync) begin
      errorCount = 0;
    end else if (csrReady) begin
      if (!expValid) begin
        $display("error at %0t: ready seen without a pending request", $time);
        errorCount++;
      end else begin
        if (csrRdata !== expData) begin
          $display("mismatch at %0t: address %0h read data %h, expected %h",
                   $time, csrAddress, csrRdata, expData);
          errorCount++;
        end
        if (csrError !== expError) begin
          $display("mismatch at %0t: address %0h error flag %b, expected %b",
                   $time, csrAddress, csrError, expError);
          errorCount++;
        end
      end
    end
  end

endmodule

/* testbench/timerStim.txt */
# op (R read, W write, I wait irq high, N wait irq low), address, write data,
# expected read data, expected error; numbers in hex, write data unused by R, I and N
R 0 00000000 00000000 0
R 1 00000000 00000000 0
R 2 00000000 00000000 0
R 3 00000000 00000000 0
R 4 00000000 71AE0001 0
N 0 00000000 00000000 0
W 1 FFFFFFFF 00000000 0
R 1 00000000 0000FFFF 0
W 2 FFFFFFFF 00000000 0
R 2 00000000 00000000 0
W 3 FFFFFFFF 00000000 0
R 3 00000000 00000000 0
W 4 FFFFFFFF 00000000 0
R 4 00000000 71AE0001 0
W 0 FFFFFFFF 00000000 0
R 0 00000000 00000007 0
W 0 00000000 00000000 0
R 2 00000000 00000000 0
R 5 00000000 00000000 1
W 7 DEADBEEF 00000000 1
R F 00000000 00000000 1
W 1 0000000A 00000000 0
W 0 00000007 00000000 0
I 0 00000000 00000000 0
R 3 00000000 00000001 0
N 0 00000000 00000000 0
R 3 00000000 00000000 0
W 0 00000000 00000000 0
W 1 00000004 00000000 0
W 0 00000005 00000000 0
I 0 00000000 00000000 0
R 3 00000000 00000003 0
N 0 00000000 00000000 0
I 0 00000000 00000000 0
W 0 00000000 00000000 0
R 3 00000000 00000001 0
R 3 00000000 00000000 0
R 2 00000000 00000000 0

/* testbench/timerTb.sv */
// reads testbench/timerStim.txt relative to the project root; one bus access in flight at a time
`timescale 1ns/1ps

module timerTb;
  import csrBusPkg::*;

  localparam int TimeoutCycles = 200;

  logic             clock;
  logic             resetSync;
  logic             csrRead;
  logic             csrWrite;
  logic [AddrW-1:0] csrAddress;
  logic [DataW-1:0] csrWdata;
  logic [DataW-1:0] csrRdata;
  logic             csrReady;
  logic             csrError;
  logic             irq;
  logic             expValid;   // expected values for the access in flight
  logic [DataW-1:0] expData;
  logic             expError;
  int               mismatches;
  int               timeouts;
  int               stimErrors;

  timerTop i_timerTop (.*);

  timerChecker i_timerChecker (.errorCount(mismatches), .*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // request held until ready, dropped on the edge after it
  task automatic busAccess(input csrOpE op, input logic [AddrW-1:0] addr,
                           input logic [DataW-1:0] wdata, input logic [DataW-1:0] rdExp,
                           input logic errExp);
    int waited;
    waited = 0;
    @(posedge clock);
    csrRead    <= (op == csrOpRead);
    csrWrite   <= (op == csrOpWrite);
    csrAddress <= addr;
    csrWdata   <= wdata;
    expValid   <= 1'b1;
    expData    <= rdExp;
    expError   <= errExp;
    do begin
      @(negedge clock);
      waited++;
    end while (!csrReady && waited < TimeoutCycles);
    if (!csrReady) begin
      $display("timeout: no ready for the access at address %0h", addr);
      timeouts++;
    end
    @(posedge clock);
    csrRead  <= 1'b0;
    csrWrite <= 1'b0;
    expValid <= 1'b0;
  endtask

  task automatic waitIrq(input logic level);
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (irq !== level && waited < TimeoutCycles);
    if (irq !== level) begin
      $display("timeout: irq did not go to %b", level);
      timeouts++;
    end
  endtask

  initial begin
    int               fd;
    int               fields;
    int               executed;
    string            line;
    logic [7:0]       op;
    logic [AddrW-1:0] addr;
    logic [DataW-1:0] wdata;
    logic [DataW-1:0] rdExp;
    logic             errExp;
    csrRead    = 1'b0;
    csrWrite   = 1'b0;
    csrAddress = '0;
    csrWdata   = '0;
    expValid   = 1'b0;
    expData    = '0;
    expError   = 1'b0;
    resetSync  = 1'b1;
    timeouts   = 0;
    stimErrors = 0;
    executed   = 0;
    repeat (5) @(posedge clock);
    resetSync <= 1'b0;
    fd = $fopen("testbench/timerStim.txt", "r");
    if (fd == 0) begin
      $display("error: the stimulus file could not be opened");
      stimErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        fields = $fgets(line, fd);
        if (fields > 0 && line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, rdExp, errExp);
          executed++;
          if (fields != 5) begin
            $display("error: stimulus line has too few fields: %s", line);
            stimErrors++;
          end else begin
            case (op)
              "R": busAccess(csrOpRead, addr, wdata, rdExp, errExp);
              "W": busAccess(csrOpWrite, addr, wdata, rdExp, errExp);
              "I": waitIrq(1'b1);
              "N": waitIrq(1'b0);
              default: begin
                $display("error: unknown operation in stimulus line: %s", line);
                stimErrors++;
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end
    if (executed == 0) begin
      $display("error: no stimulus lines were run");
      stimErrors++;
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d stimulus, %0d assertions",
             mismatches, timeouts, stimErrors, i_timerTop.i_timerTopSva.failCount);
    if (mismatches + timeouts + stimErrors + i_timerTop.i_timerTopSva.failCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* testbench/timerTop_sva.sv */
// bus and irq protocol assertions bound into timerTop; bus checks are off while reset is high
`timescale 1ns/1ps

module timerTop_sva (
  input logic                        clock,
  input logic                        resetSync,
  input logic                        csrRead,
  input logic                        csrWrite,
  input logic [csrBusPkg::AddrW-1:0] csrAddress,
  input logic [csrBusPkg::DataW-1:0] csrRdata,
  input logic                        csrReady,
  input logic                        csrError,
  input logic                        irq
);
  import timerPkg::*;

  int failCount = 0;  // read by the testbench at the end

  readyOneCycle: assert property (@(posedge clock) disable iff (resetSync)
    csrReady |=> !csrReady)
    else begin
      failCount++;
      $error("csrReady stayed high for two cycles");
    end

  // address is still held in the ready cycle
  errorOnBadAddress: assert property (@(posedge clock) disable iff (resetSync)
    csrError |-> (csrAddress >= NumCsr) && (csrRdata == '0))
    else begin
      failCount++;
      $error("csrError raised for a valid address or with nonzero read data");
    end

  noReadAndWrite: assert property (@(posedge clock) disable iff (resetSync)
    !(csrRead && csrWrite))
    else begin
      failCount++;
      $error("read and write requested together");
    end

  // irq is registered, so it is low one edge into reset
  irqLowInReset: assert property (@(posedge clock) resetSync |=> !irq)
    else begin
      failCount++;
      $error("irq high during reset");
    end

endmodule

bind timerTop timerTop_sva i_timerTopSva (
  .clock      (clock),
  .resetSync  (resetSync),
  .csrRead    (csrRead),
  .csrWrite   (csrWrite),
  .csrAddress (csrAddress),
  .csrRdata   (csrRdata),
  .csrReady   (csrReady),
  .csrError   (csrError),
  .irq        (irq)
);
